// ==== mips_cpu.f ====
rtl/isa_pkg.sv
rtl/cpu_pkg.sv
rtl/control_unit.sv
rtl/regfile.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/datapath.sv
rtl/mips_cpu.sv
test/tb_clock.sv
test/mips_cpu_props.sv
test/mips_cpu_tb.sv

// ==== rtl/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  logic [cpu_pkg::xlen-1:0] a,
    input  logic [cpu_pkg::xlen-1:0] b,
    input  isa_pkg::alu_op_t         control,
    output logic [cpu_pkg::xlen-1:0] result,
    output logic                     zero
);
    import cpu_pkg::*;
    import isa_pkg::*;

    logic less;

    // Signed compare for slt
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (control)
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_slt: result = {{(xlen - 1){1'b0}}, less};
            default: result = '0;
        endcase
    end

    // Drives the beq decision
    assign zero = (result == '0);

endmodule

// ==== rtl/control_unit.sv ====
`timescale 1ns/100ps

module control_unit (
    input  logic [cpu_pkg::xlen-1:0] instr_id,
    output logic                     memtoreg,
    output logic                     memwrite,
    output logic                     alusrc,
    output logic                     regdst,
    output logic                     regwrite,
    output logic                     branch,
    output isa_pkg::alu_op_t         alucontrol
);
    import isa_pkg::*;

    opcode_t opcode;
    funct_t  funct;

    assign opcode = opcode_t'(instr_id[op_msb:op_lsb]);
    assign funct = funct_t'(instr_id[funct_msb:funct_lsb]);

    always_comb begin
        // Bubble unless decoded below
        memtoreg = 1'b0;
        memwrite = 1'b0;
        alusrc = 1'b0;
        regdst = 1'b0;
        regwrite = 1'b0;
        branch = 1'b0;
        alucontrol = alu_add;
        case (opcode)
            op_rtype: begin
                regdst = 1'b1;
                regwrite = 1'b1;
                case (funct)
                    fn_add:  alucontrol = alu_add;
                    fn_sub:  alucontrol = alu_sub;
                    fn_and:  alucontrol = alu_and;
                    fn_or:   alucontrol = alu_or;
                    fn_slt:  alucontrol = alu_slt;
                    default: regwrite = 1'b0;
                endcase
            end
            op_lw: begin
                alusrc = 1'b1;
                memtoreg = 1'b1;
                regwrite = 1'b1;
            end
            op_sw: begin
                alusrc = 1'b1;
                memwrite = 1'b1;
            end
            op_beq: begin
                branch = 1'b1;
                alucontrol = alu_sub;
            end
            op_addi: begin
                alusrc = 1'b1;
                regwrite = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count = 1 << reg_addr_w;

    // Fetch starts here after reset
    localparam logic [xlen-1:0] reset_pc = '0;
    localparam logic [xlen-1:0] pc_step = 32'd4;

    // Source of an execute-stage operand
    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

endpackage

// ==== rtl/datapath.sv ====
`timescale 1ns/100ps

module datapath (
    input  logic                     clk,
    input  logic                     rst,
    output logic [cpu_pkg::xlen-1:0] pc,
    input  logic [cpu_pkg::xlen-1:0] instr,
    output logic [cpu_pkg::xlen-1:0] instr_id,
    input  logic                     memtoreg,
    input  logic                     memwrite,
    input  logic                     alusrc,
    input  logic                     regdst,
    input  logic                     regwrite,
    input  logic                     branch,
    input  isa_pkg::alu_op_t         alucontrol,
    output logic [cpu_pkg::xlen-1:0] dmem_addr,
    output logic [cpu_pkg::xlen-1:0] dmem_wdata,
    output logic                     dmem_we,
    input  logic [cpu_pkg::xlen-1:0] dmem_rdata
);
    import cpu_pkg::*;
    import isa_pkg::*;

    logic [xlen-1:0] pcplus4_if;
    logic [xlen-1:0] pcplus4_id, rd1_id, rd2_id, signimm_id;
    logic memtoreg_ex, memwrite_ex, alusrc_ex, regdst_ex, regwrite_ex, branch_ex;
    alu_op_t alucontrol_ex;
    logic [xlen-1:0] pcplus4_ex, rd1_ex, rd2_ex, signimm_ex;
    logic [reg_addr_w-1:0] rs_ex, rt_ex, rd_ex, writereg_ex;
    logic [xlen-1:0] srca_ex, writedata_ex, srcb_ex, aluout_ex, pcbranch_ex;
    logic zero_ex;
    fwd_sel_t fwd_a, fwd_b;
    logic memtoreg_mem, memwrite_mem, regwrite_mem, branch_mem, zero_mem, pcsrc_mem;
    logic [xlen-1:0] aluout_mem, writedata_mem, pcbranch_mem;
    logic [reg_addr_w-1:0] writereg_mem;
    logic memtoreg_wb, regwrite_wb;
    logic [xlen-1:0] aluout_wb, readdata_wb, result_wb;
    logic [reg_addr_w-1:0] writereg_wb;
    logic stall, flush;

    function automatic logic [xlen-1:0] fwd_mux(
        input fwd_sel_t        sel,
        input logic [xlen-1:0] reg_val,
        input logic [xlen-1:0] mem_val,
        input logic [xlen-1:0] wb_val
    );
        logic [xlen-1:0] value;
        case (sel)
            fwd_mem: value = mem_val;
            fwd_wb:  value = wb_val;
            default: value = reg_val;
        endcase
        return value;
    endfunction

    // Fetch
    assign pcplus4_if = pc + pc_step;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (flush) begin
            pc <= pcbranch_mem;
        end else if (!stall) begin
            pc <= pcplus4_if;
        end
    end

    // IF/ID clears to the all-zero word that decodes as a bubble
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            instr_id <= '0;
        end else if (!stall) begin
            instr_id <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcplus4_id <= pcplus4_if;
        end
    end

    // Decode
    regfile regfile_inst (
        .clk (clk),
        .we  (regwrite_wb),
        .ra1 (instr_id[rs_msb:rs_lsb]),
        .ra2 (instr_id[rt_msb:rt_lsb]),
        .wa  (writereg_wb),
        .wd  (result_wb),
        .rd1 (rd1_id),
        .rd2 (rd2_id)
    );

    assign signimm_id = {{(xlen - imm_w){instr_id[imm_msb]}}, instr_id[imm_msb:imm_lsb]};

    // ID/EX takes a bubble behind the held instruction on a stall
    always_ff @(posedge clk) begin
        if (rst || flush || stall) begin
            memtoreg_ex <= 1'b0;
            memwrite_ex <= 1'b0;
            regwrite_ex <= 1'b0;
            branch_ex <= 1'b0;
        end else begin
            memtoreg_ex <= memtoreg;
            memwrite_ex <= memwrite;
            regwrite_ex <= regwrite;
            branch_ex <= branch;
        end
    end

    always_ff @(posedge clk) begin
        alusrc_ex <= alusrc;
        regdst_ex <= regdst;
        alucontrol_ex <= alucontrol;
        pcplus4_ex <= pcplus4_id;
        rd1_ex <= rd1_id;
        rd2_ex <= rd2_id;
        signimm_ex <= signimm_id;
        rs_ex <= instr_id[rs_msb:rs_lsb];
        rt_ex <= instr_id[rt_msb:rt_lsb];
        rd_ex <= instr_id[rd_msb:rd_lsb];
    end

    // Execute
    assign srca_ex = fwd_mux(fwd_a, rd1_ex, aluout_mem, result_wb);
    assign writedata_ex = fwd_mux(fwd_b, rd2_ex, aluout_mem, result_wb);
    assign srcb_ex = alusrc_ex ? signimm_ex : writedata_ex;
    assign writereg_ex = regdst_ex ? rd_ex : rt_ex;
    assign pcbranch_ex = pcplus4_ex + {signimm_ex[xlen-3:0], 2'b00};

    alu alu_inst (
        .a       (srca_ex),
        .b       (srcb_ex),
        .control (alucontrol_ex),
        .result  (aluout_ex),
        .zero    (zero_ex)
    );

    // EX/MEM
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            memtoreg_mem <= 1'b0;
            memwrite_mem <= 1'b0;
            regwrite_mem <= 1'b0;
            branch_mem <= 1'b0;
            zero_mem <= 1'b0;
        end else begin
            memtoreg_mem <= memtoreg_ex;
            memwrite_mem <= memwrite_ex;
            regwrite_mem <= regwrite_ex;
            branch_mem <= branch_ex;
            zero_mem <= zero_ex;
        end
    end

    always_ff @(posedge clk) begin
        aluout_mem <= aluout_ex;
        writedata_mem <= writedata_ex;
        writereg_mem <= writereg_ex;
        pcbranch_mem <= pcbranch_ex;
    end

    // Memory stage where the branch resolves
    assign pcsrc_mem = branch_mem && zero_mem;
    assign dmem_addr = aluout_mem;
    assign dmem_wdata = writedata_mem;
    assign dmem_we = memwrite_mem;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (rst) begin
            memtoreg_wb <= 1'b0;
            regwrite_wb <= 1'b0;
        end else begin
            memtoreg_wb <= memtoreg_mem;
            regwrite_wb <= regwrite_mem;
        end
    end

    always_ff @(posedge clk) begin
        aluout_wb <= aluout_mem;
        readdata_wb <= dmem_rdata;
        writereg_wb <= writereg_mem;
    end

    assign result_wb = memtoreg_wb ? readdata_wb : aluout_wb;

    hazard_unit hazard_unit_inst (
        .rs_id        (instr_id[rs_msb:rs_lsb]),
        .rt_id        (instr_id[rt_msb:rt_lsb]),
        .rs_ex        (rs_ex),
        .rt_ex        (rt_ex),
        .writereg_ex  (writereg_ex),
        .memtoreg_ex  (memtoreg_ex),
        .writereg_mem (writereg_mem),
        .regwrite_mem (regwrite_mem),
        .writereg_wb  (writereg_wb),
        .regwrite_wb  (regwrite_wb),
        .pcsrc_mem    (pcsrc_mem),
        .stall        (stall),
        .flush        (flush),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b)
    );

endmodule

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/100ps

module hazard_unit (
    input  logic [cpu_pkg::reg_addr_w-1:0] rs_id,
    input  logic [cpu_pkg::reg_addr_w-1:0] rt_id,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs_ex,
    input  logic [cpu_pkg::reg_addr_w-1:0] rt_ex,
    input  logic [cpu_pkg::reg_addr_w-1:0] writereg_ex,
    input  logic                           memtoreg_ex,
    input  logic [cpu_pkg::reg_addr_w-1:0] writereg_mem,
    input  logic                           regwrite_mem,
    input  logic [cpu_pkg::reg_addr_w-1:0] writereg_wb,
    input  logic                           regwrite_wb,
    input  logic                           pcsrc_mem,
    output logic                           stall,
    output logic                           flush,
    output cpu_pkg::fwd_sel_t              fwd_a,
    output cpu_pkg::fwd_sel_t              fwd_b
);
    import cpu_pkg::*;

    // Memory stage has the younger result, so it wins
    function automatic fwd_sel_t fwd_select(input logic [reg_addr_w-1:0] src);
        fwd_sel_t sel;
        if (src == '0) begin
            sel = fwd_none;
        end else if (regwrite_mem && writereg_mem == src) begin
            sel = fwd_mem;
        end else if (regwrite_wb && writereg_wb == src) begin
            sel = fwd_wb;
        end else begin
            sel = fwd_none;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = fwd_select(rs_ex);
        fwd_b = fwd_select(rt_ex);
    end

    // Load in execute feeding the instruction in decode
    assign stall = memtoreg_ex && writereg_ex != '0 &&
                   (writereg_ex == rs_id || writereg_ex == rt_id);

    assign flush = pcsrc_mem;

endmodule

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    // Instruction field positions
    localparam int op_msb = 31;
    localparam int op_lsb = 26;
    localparam int rs_msb = 25;
    localparam int rs_lsb = 21;
    localparam int rt_msb = 20;
    localparam int rt_lsb = 16;
    localparam int rd_msb = 15;
    localparam int rd_lsb = 11;
    localparam int funct_msb = 5;
    localparam int funct_lsb = 0;
    localparam int imm_msb = 15;
    localparam int imm_lsb = 0;
    localparam int imm_w = imm_msb - imm_lsb + 1;

    typedef enum logic [5:0] {
        op_rtype = 6'b000000,
        op_beq   = 6'b000100,
        op_addi  = 6'b001000,
        op_lw    = 6'b100011,
        op_sw    = 6'b101011
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        fn_add = 6'b100000,
        fn_sub = 6'b100010,
        fn_and = 6'b100100,
        fn_or  = 6'b100101,
        fn_slt = 6'b101010
    } funct_t;

    typedef enum logic [2:0] {
        alu_and = 3'b000,
        alu_or  = 3'b001,
        alu_add = 3'b010,
        alu_sub = 3'b110,
        alu_slt = 3'b111
    } alu_op_t;

endpackage

// ==== rtl/mips_cpu.sv ====
`timescale 1ns/100ps

module mips_cpu (
    input  logic                     clk,
    input  logic                     rst,
    output logic [cpu_pkg::xlen-1:0] pc,
    input  logic [cpu_pkg::xlen-1:0] instr,
    output logic [cpu_pkg::xlen-1:0] dmem_addr,
    output logic [cpu_pkg::xlen-1:0] dmem_wdata,
    output logic                     dmem_we,
    input  logic [cpu_pkg::xlen-1:0] dmem_rdata
);
    import cpu_pkg::*;
    import isa_pkg::*;

    logic [xlen-1:0] instr_id;
    logic memtoreg, memwrite, alusrc, regdst, regwrite, branch;
    alu_op_t alucontrol;

    // Decode controls for the instruction held in IF/ID
    control_unit control_unit_inst (
        .instr_id,
        .memtoreg,
        .memwrite,
        .alusrc,
        .regdst,
        .regwrite,
        .branch,
        .alucontrol
    );

    datapath datapath_inst (
        .clk,
        .rst,
        .pc,
        .instr,
        .instr_id,
        .memtoreg,
        .memwrite,
        .alusrc,
        .regdst,
        .regwrite,
        .branch,
        .alucontrol,
        .dmem_addr,
        .dmem_wdata,
        .dmem_we,
        .dmem_rdata
    );

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic                           clk,
    input  logic                           we,
    input  logic [cpu_pkg::reg_addr_w-1:0] ra1,
    input  logic [cpu_pkg::reg_addr_w-1:0] ra2,
    input  logic [cpu_pkg::reg_addr_w-1:0] wa,
    input  logic [cpu_pkg::xlen-1:0]       wd,
    output logic [cpu_pkg::xlen-1:0]       rd1,
    output logic [cpu_pkg::xlen-1:0]       rd2
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    // Writeback value is visible to decode in the same cycle
    function automatic logic [xlen-1:0] read_reg(input logic [reg_addr_w-1:0] ra);
        logic [xlen-1:0] value;
        if (ra == '0) begin
            value = '0;
        end else if (we && ra == wa) begin
            value = wd;
        end else begin
            value = regs[ra];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd1 = read_reg(ra1);
        rd2 = read_reg(ra2);
    end

endmodule

// ==== test/mips_cpu_props.sv ====
`timescale 1ns/100ps

module mips_cpu_props (
    input logic                     clk,
    input logic                     rst,
    input logic [cpu_pkg::xlen-1:0] pc,
    input logic                     stall,
    input logic                     flush,
    input logic                     dmem_we
);
    int unsigned fail_count = 0;

    // Reset clears the memory-stage write enable
    we_low_in_reset: assert property (@(posedge clk) rst |=> !dmem_we)
        else begin
            fail_count++;
            $error("dmem_we high after a reset cycle");
        end

    flushed_slot_no_store: assert property (
        @(posedge clk) disable iff (rst) flush |=> !dmem_we)
        else begin
            fail_count++;
            $error("store issued from a flushed slot");
        end

    // The bubble behind a load removes the hazard
    stall_single_cycle: assert property (
        @(posedge clk) disable iff (rst) stall |=> !stall)
        else begin
            fail_count++;
            $error("stall held for two cycles");
        end

    pc_held_on_stall: assert property (
        @(posedge clk) disable iff (rst) (stall && !flush) |=> $stable(pc))
        else begin
            fail_count++;
            $error("pc moved during a stall");
        end

endmodule

// ==== test/mips_cpu_tb.sv ====
`timescale 1ns/100ps

module mips_cpu_tb;
    import cpu_pkg::*;
    import isa_pkg::*;

    localparam int imem_words = 128;
    localparam int dmem_words = 64;
    localparam int body_len = 60;
    localparam int store_timeout = 200;

    logic clk;
    logic rst;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] dmem_addr;
    logic [xlen-1:0] dmem_wdata;
    logic [xlen-1:0] dmem_rdata;
    logic dmem_we;

    logic [xlen-1:0] imem [imem_words];
    logic [xlen-1:0] dmem [dmem_words];
    logic [31:0] lfsr_state;
    int loop_index;

    // Stores in program order, as the ISA model performs them
    logic [xlen-1:0] exp_addr [$];
    logic [xlen-1:0] exp_data [$];

    tb_clock clock_inst (
        .clk (clk)
    );

    mips_cpu mips_cpu_inst (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .instr      (instr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    bind datapath mips_cpu_props mips_cpu_props_inst (
        .clk     (clk),
        .rst     (rst),
        .pc      (pc),
        .stall   (stall),
        .flush   (flush),
        .dmem_we (dmem_we)
    );

    assign instr = imem[pc[8:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    // Write lands 2 ns after the edge that takes it
    always @(posedge clk) begin : dmem_write
        logic [5:0] wr_index;
        logic [xlen-1:0] wr_data;
        if (dmem_we === 1'b1) begin
            wr_index = dmem_addr[7:2];
            wr_data = dmem_wdata;
            #2;
            dmem[wr_index] = wr_data;
        end
    end

    // A failed pipeline assertion ends the run at once
    always @(negedge clk) begin
        if (mips_cpu_inst.datapath_inst.mips_cpu_props_inst.fail_count != 0) begin
            $display("A pipeline assertion failed during the run");
            stop_run();
        end
    end

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] encode_r(input funct_t fn, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd);
        logic [31:0] word;
        word = '0;
        word[op_msb:op_lsb] = op_rtype;
        word[rs_msb:rs_lsb] = rs;
        word[rt_msb:rt_lsb] = rt;
        word[rd_msb:rd_lsb] = rd;
        word[funct_msb:funct_lsb] = fn;
        return word;
    endfunction

    function automatic logic [31:0] encode_i(input opcode_t op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        logic [31:0] word;
        word = '0;
        word[op_msb:op_lsb] = op;
        word[rs_msb:rs_lsb] = rs;
        word[rt_msb:rt_lsb] = rt;
        word[imm_msb:imm_lsb] = imm;
        return word;
    endfunction

    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [xlen-1:0] actual,
                                 input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic fill_memories();
        // Unused words are bubbles with the address in the rs/rt/rd bits
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = {6'b000000, 20'(i), 6'b000000};
        end
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = 32'hc0de_0000 + i * 32'h0001_0003;
        end
    endtask

    task automatic build_program();
        funct_t fn_table [5] = '{fn_add, fn_sub, fn_and, fn_or, fn_slt};
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        int kind;
        int at;
        at = 0;
        // Registers 1 to 7 get defined values first
        for (int r = 1; r < 8; r++) begin
            imem[at] = encode_i(op_addi, 5'd0, 5'(r), 16'(take_bits(16)));
            at++;
        end
        for (int i = 0; i < body_len; i++) begin
            kind = int'(take_bits(3));
            // Keep branch targets inside the random body or at the dump
            if (kind == 7 && i > body_len - 5) begin
                kind = 0;
            end
            rs = 5'(take_bits(3));
            rt = 5'(take_bits(3));
            case (kind)
                0, 1, 2: begin
                    rd = 5'(take_bits(3));
                    imem[at] = encode_r(fn_table[take_bits(3) % 5], rs, rt, rd);
                end
                3: imem[at] = encode_i(op_addi, rs, rt, 16'(take_bits(16)));
                4: imem[at] = encode_i(op_lw, 5'd0, rt, 16'(take_bits(6) * 4));
                5, 6: imem[at] = encode_i(op_sw, 5'd0, rt, 16'(take_bits(6) * 4));
                default: imem[at] = encode_i(op_beq, rs, rt, 16'(take_bits(2) + 1));
            endcase
            at++;
        end
        for (int r = 1; r < 8; r++) begin
            imem[at] = encode_i(op_sw, 5'd0, 5'(r), 16'((55 + r) * 4));
            at++;
        end
        loop_index = at;
        imem[at] = encode_i(op_beq, 5'd0, 5'd0, 16'hffff);
    endtask

    // Sequential ISA model, one instruction per step
    task automatic run_model();
        logic [xlen-1:0] regs [32];
        logic [xlen-1:0] mem [dmem_words];
        logic [xlen-1:0] word;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm;
        int index;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < dmem_words; i++) begin
            mem[i] = dmem[i];
        end
        index = 0;
        while (index != loop_index) begin
            word = imem[index];
            a = regs[word[rs_msb:rs_lsb]];
            b = regs[word[rt_msb:rt_lsb]];
            imm = {{(xlen - 16){word[imm_msb]}}, word[imm_msb:imm_lsb]};
            index++;
            case (opcode_t'(word[op_msb:op_lsb]))
                op_rtype: begin
                    case (funct_t'(word[funct_msb:funct_lsb]))
                        fn_add: regs[word[rd_msb:rd_lsb]] = a + b;
                        fn_sub: regs[word[rd_msb:rd_lsb]] = a - b;
                        fn_and: regs[word[rd_msb:rd_lsb]] = a & b;
                        fn_or:  regs[word[rd_msb:rd_lsb]] = a | b;
                        fn_slt: regs[word[rd_msb:rd_lsb]] = ($signed(a) < $signed(b)) ? 1 : 0;
                        default: ;
                    endcase
                end
                op_addi: regs[word[rt_msb:rt_lsb]] = a + imm;
                op_lw: regs[word[rt_msb:rt_lsb]] = mem[(a + imm) >> 2];
                op_sw: begin
                    mem[(a + imm) >> 2] = b;
                    exp_addr.push_back(a + imm);
                    exp_data.push_back(b);
                end
                op_beq: begin
                    if (a == b) begin
                        index = index + $signed(imm);
                    end
                end
                default: ;
            endcase
            regs[0] = '0;
        end
    endtask

    task automatic wait_for_store(input int number);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (dmem_we !== 1'b1 && cycles < store_timeout);
        if (dmem_we !== 1'b1) begin
            $display("No store appeared within %0d cycles while waiting for store %0d",
                     store_timeout, number);
            stop_run();
        end
    endtask

    task automatic expect_quiet();
        for (int c = 0; c < store_timeout; c++) begin
            @(negedge clk);
            if (dmem_we !== 1'b0) begin
                $display("A store appeared after the last expected store");
                stop_run();
            end
        end
    endtask

    initial begin : main
        rst = 1'b1;
        lfsr_state = 32'h2423;
        fill_memories();
        build_program();
        run_model();
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        compare_value("pc", pc, reset_pc);
        compare_value("dmem_we", dmem_we, 1'b0);
        for (int k = 0; k < exp_addr.size(); k++) begin
            wait_for_store(k);
            compare_value("dmem_addr", dmem_addr, exp_addr[k]);
            compare_value("dmem_wdata", dmem_wdata, exp_data[k]);
        end
        expect_quiet();
        if (mips_cpu_inst.datapath_inst.mips_cpu_props_inst.fail_count != 0) begin
            $display("A pipeline assertion failed during the run");
            stop_run();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic clk
);
    localparam int half_period = 20;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

endmodule
